//--- hdl/mmu_macros.svh
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// Address widths
`define VADDR_SIZE 32
`define PADDR_SIZE 32
`define PAGE_OFFSET 12

// Two page-number levels of 10 bits, level 1 on top
`define VPN_PART 10
`define TLB_PN 2
`define VPN_SIZE (`TLB_PN * `VPN_PART)
`define PPN_SIZE (`PADDR_SIZE - `PAGE_OFFSET)

// Default number of entries per TLB
`define TLB_DEPTH 16

`define PMP_REGIONS 4

// Uncached window, 0x1000_0000 up to 0x1fff_ffff, as page number and mask
`define UC_BASE 20'h1_0000
`define UC_MASK 20'hf_0000

`endif

//--- hdl/mmu_pkg.sv
`include "mmu_macros.svh"

package mmu_pkg;

    typedef logic [`VADDR_SIZE-1:0] vaddr_t;
    typedef logic [`PADDR_SIZE-1:0] paddr_t;

    // Level 1 in the upper VPN_PART bits
    typedef logic [`VPN_SIZE-1:0] vpn_t;
    typedef logic [`PPN_SIZE-1:0] ppn_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_t;

    // Sv32 PTE order, v in bit 0
    typedef struct packed {
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } pte_flags_t;

    // Same order as a pmpcfg byte, r in bit 0
    typedef struct packed {
        logic x;
        logic w;
        logic r;
    } pmp_perm_t;

    typedef struct packed {
        vpn_t       vpn;
        ppn_t       ppn;
        pte_flags_t flags;
        logic       superpage;
        logic       exc;
    } tlb_entry_t;

    typedef enum logic [1:0] {
        IDLE,
        FENCE,
        FENCE_ALL,
        FENCE_END
    } fence_state_t;

    typedef enum logic {
        FETCH,
        LOAD
    } access_t;

endpackage

//--- hdl/pri_encoder.sv
module pri_encoder #(
    parameter int WIDTH = 16,
    localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
    input  logic [WIDTH-1:0] vec,
    output logic [IDX_W-1:0] idx
);

    // Scan downwards so the lowest set bit is the last one written
    always_comb begin
        idx = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = IDX_W'(i);
            end
        end
    end

endmodule

//--- hdl/pmp_check.sv
`include "mmu_macros.svh"

module pmp_check (
    input  mmu_pkg::ppn_t      ppn,
    input  mmu_pkg::access_t   access,
    input  mmu_pkg::ppn_t      pmp_base [`PMP_REGIONS],
    input  mmu_pkg::ppn_t      pmp_mask [`PMP_REGIONS],
    input  mmu_pkg::pmp_perm_t pmp_perm [`PMP_REGIONS],
    output logic               pmp_fault,
    output logic               uncache
);

    logic [`PMP_REGIONS-1:0] match;
    mmu_pkg::pmp_perm_t      sel_perm;
    logic                    any_match;

    for (genvar i = 0; i < `PMP_REGIONS; i++) begin : g_region
        mmu_pkg::ppn_t mask_inv;
        logic          enabled;

        // Region with no permission bits is switched off
        assign enabled = (pmp_perm[i] != '0);
        assign mask_inv = ~pmp_mask[i];
        assign match[i] = enabled &&
                          ((ppn & pmp_mask[i]) == (pmp_base[i] & pmp_mask[i]));

        // Inverted mask must be a run of ones from bit 0 upwards
        always_comb begin
            if (enabled) begin
                a_mask_contig: assert ((mask_inv & (mask_inv + 1'b1)) == '0)
                    else $error("pmp region %0d has a mask that is not contiguous", i);
            end
        end
    end

    // Lowest matching region wins
    always_comb begin
        sel_perm = '0;
        any_match = 1'b0;
        for (int i = `PMP_REGIONS - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel_perm = pmp_perm[i];
                any_match = 1'b1;
            end
        end
    end

    assign pmp_fault = any_match &&
                       ((access == mmu_pkg::FETCH) ? !sel_perm.x : !sel_perm.r);

    assign uncache = ((ppn & `UC_MASK) == `UC_BASE);

endmodule

//--- hdl/l1_tlb.sv
`include "mmu_macros.svh"

module l1_tlb #(
    parameter int               DEPTH  = `TLB_DEPTH,
    parameter mmu_pkg::access_t ACCESS = mmu_pkg::FETCH
) (
    input  logic                      clk,
    input  logic                      rst,
    // Lookup
    input  logic                      req,
    input  mmu_pkg::vaddr_t           vaddr,
    output logic                      miss,
    output logic                      exception,
    output logic                      uncache,
    output mmu_pkg::paddr_t           paddr,
    // Refill
    input  logic                      we,
    input  logic [$clog2(DEPTH)-1:0]  widx,
    input  mmu_pkg::vaddr_t           wvaddr,
    input  mmu_pkg::ppn_t             wppn,
    input  mmu_pkg::pte_flags_t       wflags,
    input  logic                      wsuper,
    // Fence
    input  logic                      fence_valid,
    input  logic                      fence_all,
    input  mmu_pkg::vaddr_t           fence_vaddr,
    output logic                      fence_ready,
    // Shared control
    input  mmu_pkg::priv_t            priv,
    input  logic                      satp_on,
    input  logic                      sum,
    input  logic                      mxr,
    input  mmu_pkg::ppn_t             pmp_base [`PMP_REGIONS],
    input  mmu_pkg::ppn_t             pmp_mask [`PMP_REGIONS],
    input  mmu_pkg::pmp_perm_t        pmp_perm [`PMP_REGIONS]
);

    localparam int IDX_W = $clog2(DEPTH);

    mmu_pkg::tlb_entry_t   entries [DEPTH];
    logic [DEPTH-1:0]      valid;
    mmu_pkg::tlb_entry_t   new_entry;

    mmu_pkg::fence_state_t fence_state;
    mmu_pkg::vpn_t         fence_vpn;
    logic                  fence_we;
    logic                  fence_end_hold;
    logic [IDX_W-1:0]      walk_idx;
    logic [DEPTH-1:0]      hit_q;
    logic [IDX_W-1:0]      hit_q_idx;
    logic                  fence_inv;
    logic [IDX_W-1:0]      fence_idx;

    mmu_pkg::vpn_t         req_vpn;
    mmu_pkg::vpn_t         lookup_vpn;
    logic [DEPTH-1:0]      hit;
    logic [IDX_W-1:0]      hit_idx;
    mmu_pkg::tlb_entry_t   hit_entry;
    mmu_pkg::ppn_t         trans_ppn;
    mmu_pkg::ppn_t         check_ppn;
    logic                  bypass;
    logic                  hit_ok;
    logic                  load_exc;
    logic                  perm_exc;
    logic                  pmp_fault;
    logic                  pmp_uncache;

    assign req_vpn = vaddr[`VADDR_SIZE-1:`PAGE_OFFSET];
    // Fence borrows the match logic for one cycle
    assign lookup_vpn = (fence_state == mmu_pkg::FENCE) ? fence_vpn : req_vpn;
    assign bypass = (priv == mmu_pkg::PRIV_M) || !satp_on;

    for (genvar i = 0; i < DEPTH; i++) begin : g_match
        logic [`TLB_PN-1:0] pn_eq;
        logic [`TLB_PN-1:0] pn_skip;

        for (genvar l = 0; l < `TLB_PN; l++) begin : g_level
            assign pn_eq[l] = (entries[i].vpn[l*`VPN_PART +: `VPN_PART] ==
                               lookup_vpn[l*`VPN_PART +: `VPN_PART]);
        end
        // Superpage ignores level 0
        assign pn_skip = {{(`TLB_PN-1){1'b0}}, entries[i].superpage};
        assign hit[i] = valid[i] && (&(pn_eq | pn_skip));
    end

    pri_encoder #(.WIDTH(DEPTH)) hit_enc (
        .vec (hit),
        .idx (hit_idx)
    );

    assign hit_entry = entries[hit_idx];
    assign trans_ppn = hit_entry.superpage ?
                       {hit_entry.ppn[`PPN_SIZE-1:`VPN_PART], req_vpn[`VPN_PART-1:0]} :
                       hit_entry.ppn;
    assign check_ppn = bypass ? mmu_pkg::ppn_t'(req_vpn) : trans_ppn;

    pmp_check pmp (
        .ppn       (check_ppn),
        .access    (ACCESS),
        .pmp_base  (pmp_base),
        .pmp_mask  (pmp_mask),
        .pmp_perm  (pmp_perm),
        .pmp_fault (pmp_fault),
        .uncache   (pmp_uncache)
    );

    // mxr may change after refill, so loads check r/x here
    if (ACCESS == mmu_pkg::LOAD) begin : g_load_perm
        assign load_exc = !hit_entry.flags.r && !(hit_entry.flags.x && mxr);
    end else begin : g_fetch_perm
        assign load_exc = 1'b0;
    end

    assign perm_exc = ((priv == mmu_pkg::PRIV_U) && !hit_entry.flags.u) ||
                      ((priv == mmu_pkg::PRIV_S) && !sum && hit_entry.flags.u) ||
                      hit_entry.exc || load_exc || pmp_fault;

    // A busy fence turns every translated request into a miss
    assign hit_ok = (|hit) && fence_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            miss <= 1'b0;
            exception <= 1'b0;
            uncache <= 1'b0;
        end else if (req) begin
            miss <= !bypass && !hit_ok;
            exception <= !bypass && hit_ok && perm_exc;
            uncache <= pmp_uncache && (bypass || hit_ok);
        end else begin
            miss <= 1'b0;
            exception <= 1'b0;
            uncache <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            paddr <= bypass ? vaddr : {trans_ppn, vaddr[`PAGE_OFFSET-1:0]};
        end
    end

    always_comb begin
        new_entry.vpn = wvaddr[`VADDR_SIZE-1:`PAGE_OFFSET];
        new_entry.ppn = wppn;
        new_entry.flags = wflags;
        new_entry.superpage = wsuper;
        new_entry.exc = (ACCESS == mmu_pkg::FETCH) && !wflags.x;
    end

    assign fence_inv = fence_we && ((fence_state == mmu_pkg::FENCE_ALL) || (|hit_q));
    assign fence_idx = (fence_state == mmu_pkg::FENCE_ALL) ? walk_idx : hit_q_idx;

    // Refill is dropped when a fence clears an entry in the same cycle
    always_ff @(posedge clk) begin
        if (we && !fence_inv) begin
            entries[widx] <= new_entry;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (fence_inv) begin
            valid[fence_idx] <= 1'b0;
        end else if (we) begin
            valid[widx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        hit_q <= hit;
    end

    pri_encoder #(.WIDTH(DEPTH)) fence_enc (
        .vec (hit_q),
        .idx (hit_q_idx)
    );

    assign fence_ready = (fence_state == mmu_pkg::IDLE);

    always_ff @(posedge clk) begin
        if (fence_valid && fence_ready) begin
            fence_vpn <= fence_vaddr[`VADDR_SIZE-1:`PAGE_OFFSET];
        end
    end

    // FENCE_END lasts two cycles for both kinds of fence
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fence_state <= mmu_pkg::IDLE;
            fence_we <= 1'b0;
            fence_end_hold <= 1'b0;
            walk_idx <= '0;
        end else begin
            case (fence_state)
                mmu_pkg::IDLE: begin
                    if (fence_valid) begin
                        walk_idx <= '0;
                        if (fence_all) begin
                            fence_we <= 1'b1;
                            fence_state <= mmu_pkg::FENCE_ALL;
                        end else begin
                            fence_state <= mmu_pkg::FENCE;
                        end
                    end
                end
                mmu_pkg::FENCE: begin
                    fence_we <= 1'b1;
                    fence_end_hold <= 1'b1;
                    fence_state <= mmu_pkg::FENCE_END;
                end
                mmu_pkg::FENCE_ALL: begin
                    walk_idx <= walk_idx + 1'b1;
                    if (walk_idx == IDX_W'(DEPTH - 1)) begin
                        fence_we <= 1'b0;
                        fence_end_hold <= 1'b1;
                        fence_state <= mmu_pkg::FENCE_END;
                    end
                end
                mmu_pkg::FENCE_END: begin
                    fence_we <= 1'b0;
                    fence_end_hold <= 1'b0;
                    if (!fence_end_hold) begin
                        fence_state <= mmu_pkg::IDLE;
                    end
                end
                default: begin
                    fence_state <= mmu_pkg::IDLE;
                end
            endcase
        end
    end

    a_refill_idx: assert property (@(posedge clk) disable iff (rst)
        we |-> (widx < DEPTH))
        else $error("refill index out of range");

    a_fence_idx: assert property (@(posedge clk) disable iff (rst)
        fence_inv |-> (fence_idx < DEPTH))
        else $error("fence index out of range");

    a_miss_exc: assert property (@(posedge clk) disable iff (rst)
        !(miss && exception))
        else $error("miss and exception both high");

endmodule

//--- hdl/mmu_l1.sv
`include "mmu_macros.svh"

module mmu_l1 (
    input  logic                          clk,
    input  logic                          rst,
    // Instruction side
    input  logic                          i_req,
    input  mmu_pkg::vaddr_t               i_vaddr,
    output logic                          i_miss,
    output logic                          i_exception,
    output logic                          i_uncache,
    output mmu_pkg::paddr_t               i_paddr,
    input  logic                          i_we,
    input  logic [$clog2(`TLB_DEPTH)-1:0] i_widx,
    input  mmu_pkg::vaddr_t               i_wvaddr,
    input  mmu_pkg::ppn_t                 i_wppn,
    input  mmu_pkg::pte_flags_t           i_wflags,
    input  logic                          i_wsuper,
    input  logic                          i_fence_valid,
    input  logic                          i_fence_all,
    input  mmu_pkg::vaddr_t               i_fence_vaddr,
    output logic                          i_fence_ready,
    // Data side
    input  logic                          d_req,
    input  mmu_pkg::vaddr_t               d_vaddr,
    output logic                          d_miss,
    output logic                          d_exception,
    output logic                          d_uncache,
    output mmu_pkg::paddr_t               d_paddr,
    input  logic                          d_we,
    input  logic [$clog2(`TLB_DEPTH)-1:0] d_widx,
    input  mmu_pkg::vaddr_t               d_wvaddr,
    input  mmu_pkg::ppn_t                 d_wppn,
    input  mmu_pkg::pte_flags_t           d_wflags,
    input  logic                          d_wsuper,
    input  logic                          d_fence_valid,
    input  logic                          d_fence_all,
    input  mmu_pkg::vaddr_t               d_fence_vaddr,
    output logic                          d_fence_ready,
    // Control shared by both TLBs
    input  mmu_pkg::priv_t                priv,
    input  logic                          satp_on,
    input  logic                          sum,
    input  logic                          mxr,
    input  mmu_pkg::ppn_t                 pmp_base [`PMP_REGIONS],
    input  mmu_pkg::ppn_t                 pmp_mask [`PMP_REGIONS],
    input  mmu_pkg::pmp_perm_t            pmp_perm [`PMP_REGIONS]
);

    l1_tlb #(.DEPTH(`TLB_DEPTH), .ACCESS(mmu_pkg::FETCH)) itlb (
        .clk (clk), .rst (rst),
        .req (i_req), .vaddr (i_vaddr),
        .miss (i_miss), .exception (i_exception),
        .uncache (i_uncache), .paddr (i_paddr),
        .we (i_we), .widx (i_widx), .wvaddr (i_wvaddr),
        .wppn (i_wppn), .wflags (i_wflags), .wsuper (i_wsuper),
        .fence_valid (i_fence_valid), .fence_all (i_fence_all),
        .fence_vaddr (i_fence_vaddr), .fence_ready (i_fence_ready),
        .priv (priv), .satp_on (satp_on), .sum (sum), .mxr (mxr),
        .pmp_base (pmp_base), .pmp_mask (pmp_mask), .pmp_perm (pmp_perm)
    );

    l1_tlb #(.DEPTH(`TLB_DEPTH), .ACCESS(mmu_pkg::LOAD)) dtlb (
        .clk (clk), .rst (rst),
        .req (d_req), .vaddr (d_vaddr),
        .miss (d_miss), .exception (d_exception),
        .uncache (d_uncache), .paddr (d_paddr),
        .we (d_we), .widx (d_widx), .wvaddr (d_wvaddr),
        .wppn (d_wppn), .wflags (d_wflags), .wsuper (d_wsuper),
        .fence_valid (d_fence_valid), .fence_all (d_fence_all),
        .fence_vaddr (d_fence_vaddr), .fence_ready (d_fence_ready),
        .priv (priv), .satp_on (satp_on), .sum (sum), .mxr (mxr),
        .pmp_base (pmp_base), .pmp_mask (pmp_mask), .pmp_perm (pmp_perm)
    );

endmodule

//--- tb/tb_mmu_l1.sv
`include "mmu_macros.svh"

module tb_mmu_l1;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int NUM_TESTS = 6;
    localparam int IDX_W = $clog2(`TLB_DEPTH);

    logic                clk;
    logic                rst;
    // Index 0 is the instruction TLB, index 1 the data TLB
    logic [1:0]          req;
    mmu_pkg::vaddr_t     vaddr [2];
    logic [1:0]          we;
    logic [IDX_W-1:0]    widx [2];
    mmu_pkg::vaddr_t     wvaddr [2];
    mmu_pkg::ppn_t       wppn [2];
    mmu_pkg::pte_flags_t wflags [2];
    logic [1:0]          wsuper;
    logic [1:0]          fence_valid;
    logic [1:0]          fence_all;
    mmu_pkg::vaddr_t     fence_vaddr [2];
    wire [1:0]           miss;
    wire [1:0]           exception;
    wire [1:0]           uncache;
    wire [1:0]           fence_ready;
    wire mmu_pkg::paddr_t paddr [2];

    mmu_pkg::priv_t      priv;
    logic                satp_on;
    logic                sum;
    logic                mxr;
    mmu_pkg::ppn_t       pmp_base [`PMP_REGIONS];
    mmu_pkg::ppn_t       pmp_mask [`PMP_REGIONS];
    mmu_pkg::pmp_perm_t  pmp_perm [`PMP_REGIONS];

    // Reference model of both TLBs
    logic                m_valid [2][`TLB_DEPTH];
    mmu_pkg::vpn_t       m_vpn [2][`TLB_DEPTH];
    mmu_pkg::ppn_t       m_ppn [2][`TLB_DEPTH];
    mmu_pkg::pte_flags_t m_flags [2][`TLB_DEPTH];
    logic                m_super [2][`TLB_DEPTH];
    logic [1:0]          fence_busy;

    logic [1:0]          exp_miss;
    logic [1:0]          exp_exc;
    logic [1:0]          exp_unc;
    mmu_pkg::paddr_t     exp_paddr [2];
    logic [1:0]          req_q;
    logic [1:0]          exp_miss_q;
    logic [1:0]          exp_exc_q;
    logic [1:0]          exp_unc_q;
    mmu_pkg::paddr_t     exp_paddr_q [2];

    int seed = 32'hfe97_1091;
    int err_count = 0;
    int err_mark = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    mmu_l1 i_mmu_l1 (
        .clk (clk), .rst (rst),
        .i_req (req[0]), .i_vaddr (vaddr[0]),
        .i_miss (miss[0]), .i_exception (exception[0]),
        .i_uncache (uncache[0]), .i_paddr (paddr[0]),
        .i_we (we[0]), .i_widx (widx[0]), .i_wvaddr (wvaddr[0]),
        .i_wppn (wppn[0]), .i_wflags (wflags[0]), .i_wsuper (wsuper[0]),
        .i_fence_valid (fence_valid[0]), .i_fence_all (fence_all[0]),
        .i_fence_vaddr (fence_vaddr[0]), .i_fence_ready (fence_ready[0]),
        .d_req (req[1]), .d_vaddr (vaddr[1]),
        .d_miss (miss[1]), .d_exception (exception[1]),
        .d_uncache (uncache[1]), .d_paddr (paddr[1]),
        .d_we (we[1]), .d_widx (widx[1]), .d_wvaddr (wvaddr[1]),
        .d_wppn (wppn[1]), .d_wflags (wflags[1]), .d_wsuper (wsuper[1]),
        .d_fence_valid (fence_valid[1]), .d_fence_all (fence_all[1]),
        .d_fence_vaddr (fence_vaddr[1]), .d_fence_ready (fence_ready[1]),
        .priv (priv), .satp_on (satp_on), .sum (sum), .mxr (mxr),
        .pmp_base (pmp_base), .pmp_mask (pmp_mask), .pmp_perm (pmp_perm)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Expectations follow the request by one cycle, like the DUT result
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q <= '0;
        end else begin
            req_q <= req;
            exp_miss_q <= exp_miss;
            exp_exc_q <= exp_exc;
            exp_unc_q <= exp_unc;
            exp_paddr_q <= exp_paddr;
        end
    end

    for (genvar s = 0; s < 2; s++) begin : g_check
        a_result: assert property (@(posedge clk) disable iff (rst)
            req_q[s] |-> (miss[s] == exp_miss_q[s] && exception[s] == exp_exc_q[s] &&
                          uncache[s] == exp_unc_q[s]))
            else begin
                err_count++;
                $display("Fail %0t: %s miss/exception/uncache %b%b%b, expected %b%b%b",
                         $time, (s == 0) ? "itlb" : "dtlb", $sampled(miss[s]),
                         $sampled(exception[s]), $sampled(uncache[s]),
                         $sampled(exp_miss_q[s]), $sampled(exp_exc_q[s]),
                         $sampled(exp_unc_q[s]));
            end

        a_paddr: assert property (@(posedge clk) disable iff (rst)
            (req_q[s] && !exp_miss_q[s]) |-> (paddr[s] == exp_paddr_q[s]))
            else begin
                err_count++;
                $display("Fail %0t: %s paddr %h, expected %h", $time,
                         (s == 0) ? "itlb" : "dtlb", $sampled(paddr[s]),
                         $sampled(exp_paddr_q[s]));
            end

        a_quiet: assert property (@(posedge clk) disable iff (rst)
            !req_q[s] |-> (!miss[s] && !exception[s] && !uncache[s]))
            else begin
                err_count++;
                $display("Fail %0t: %s raised a result without a request", $time,
                         (s == 0) ? "itlb" : "dtlb");
            end
    end

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic mmu_pkg::pte_flags_t make_flags(input logic r, input logic x,
                                                       input logic u);
        mmu_pkg::pte_flags_t f;
        f = '0;
        f.v = 1'b1;
        f.r = r;
        f.x = x;
        f.u = u;
        return f;
    endfunction

    function automatic logic entry_matches(input int s, input int i, input mmu_pkg::vpn_t vpn);
        return m_valid[s][i] && (m_vpn[s][i][19:10] == vpn[19:10]) &&
               (m_super[s][i] || (m_vpn[s][i][9:0] == vpn[9:0]));
    endfunction

    // Lowest enabled region that covers the page decides
    function automatic logic pmp_denies(input int s, input mmu_pkg::ppn_t ppn);
        for (int r = 0; r < `PMP_REGIONS; r++) begin
            if (pmp_perm[r] != '0 && (ppn & pmp_mask[r]) == (pmp_base[r] & pmp_mask[r])) begin
                return (s == 0) ? !pmp_perm[r].x : !pmp_perm[r].r;
            end
        end
        return 1'b0;
    endfunction

    task automatic predict(input int s, input mmu_pkg::vaddr_t va);
        mmu_pkg::vpn_t       vpn;
        mmu_pkg::ppn_t       ppn;
        mmu_pkg::pte_flags_t f;
        int                  hit_at;
        vpn = va[31:12];
        hit_at = -1;
        for (int i = `TLB_DEPTH - 1; i >= 0; i--) begin
            if (entry_matches(s, i, vpn)) begin
                hit_at = i;
            end
        end
        exp_paddr[s] = va;
        if (priv == mmu_pkg::PRIV_M || !satp_on) begin
            exp_miss[s] = 1'b0;
            exp_exc[s] = 1'b0;
            exp_unc[s] = ((vpn & `UC_MASK) == `UC_BASE);
        end else if (hit_at < 0 || fence_busy[s]) begin
            exp_miss[s] = 1'b1;
            exp_exc[s] = 1'b0;
            exp_unc[s] = 1'b0;
        end else begin
            ppn = m_ppn[s][hit_at];
            f = m_flags[s][hit_at];
            if (m_super[s][hit_at]) begin
                ppn[9:0] = vpn[9:0];
            end
            exp_miss[s] = 1'b0;
            exp_paddr[s] = {ppn, va[11:0]};
            exp_unc[s] = ((ppn & `UC_MASK) == `UC_BASE);
            exp_exc[s] = ((priv == mmu_pkg::PRIV_U) && !f.u) ||
                         ((priv == mmu_pkg::PRIV_S) && !sum && f.u) ||
                         ((s == 0) ? !f.x : (!f.r && !(f.x && mxr))) ||
                         pmp_denies(s, ppn);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic lookup(input int s, input mmu_pkg::vaddr_t va);
        req[s] = 1'b1;
        vaddr[s] = va;
        predict(s, va);
        step();
        req[s] = 1'b0;
    endtask

    task automatic refill(input int s, input int idx, input mmu_pkg::vaddr_t va,
                          input mmu_pkg::ppn_t ppn, input mmu_pkg::pte_flags_t f,
                          input logic sup);
        we[s] = 1'b1;
        widx[s] = IDX_W'(idx);
        wvaddr[s] = va;
        wppn[s] = ppn;
        wflags[s] = f;
        wsuper[s] = sup;
        step();
        we[s] = 1'b0;
        m_valid[s][idx] = 1'b1;
        m_vpn[s][idx] = va[31:12];
        m_ppn[s][idx] = ppn;
        m_flags[s][idx] = f;
        m_super[s][idx] = sup;
    endtask

    // A lookup of the fence address goes out right after acceptance
    task automatic run_fence(input int s, input logic all, input mmu_pkg::vaddr_t va,
                             input int exp_cycles);
        int cycles;
        int victim;
        fence_valid[s] = 1'b1;
        fence_all[s] = all;
        fence_vaddr[s] = va;
        step();
        fence_valid[s] = 1'b0;
        fence_busy[s] = 1'b1;
        lookup(s, va);
        cycles = 1;
        while (!fence_ready[s] && cycles < 4 * `TLB_DEPTH) begin
            step();
            cycles++;
        end
        fence_busy[s] = 1'b0;
        victim = -1;
        for (int i = `TLB_DEPTH - 1; i >= 0; i--) begin
            if (all) begin
                m_valid[s][i] = 1'b0;
            end else if (entry_matches(s, i, va[31:12])) begin
                victim = i;
            end
        end
        if (victim >= 0) begin
            m_valid[s][victim] = 1'b0;
        end
        a_fence_time: assert (cycles == exp_cycles)
            else begin
                err_count++;
                $display("Fail %0t: fence busy for %0d cycles, expected %0d",
                         $time, cycles, exp_cycles);
            end
    endtask

    task automatic finish_test(input string name);
        step();
        step();
        if (err_count == err_mark) begin
            tests_passed++;
            $display("Test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("Test %-12s %0d errors", name, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    task automatic init_inputs();
        clk = 1'b0;
        rst = 1'b1;
        req = '0;
        we = '0;
        wsuper = '0;
        fence_valid = '0;
        fence_all = '0;
        fence_busy = '0;
        exp_miss = '0;
        exp_exc = '0;
        exp_unc = '0;
        priv = mmu_pkg::PRIV_M;
        satp_on = 1'b0;
        sum = 1'b0;
        mxr = 1'b0;
        for (int s = 0; s < 2; s++) begin
            vaddr[s] = '0;
            widx[s] = '0;
            wvaddr[s] = '0;
            wppn[s] = '0;
            wflags[s] = '0;
            fence_vaddr[s] = '0;
            exp_paddr[s] = '0;
            for (int i = 0; i < `TLB_DEPTH; i++) begin
                m_valid[s][i] = 1'b0;
                m_vpn[s][i] = '0;
                m_ppn[s][i] = '0;
                m_flags[s][i] = '0;
                m_super[s][i] = 1'b0;
            end
        end
        for (int r = 0; r < `PMP_REGIONS; r++) begin
            pmp_base[r] = '0;
            pmp_mask[r] = '0;
            pmp_perm[r] = '0;
        end
    endtask

    task automatic test_bypass();
        a_ready_reset: assert (fence_ready == 2'b11)
            else begin
                err_count++;
                $display("Fail %0t: fence_ready low after reset", $time);
            end
        for (int mode = 0; mode < 2; mode++) begin
            priv = (mode == 0) ? mmu_pkg::PRIV_M : mmu_pkg::PRIV_S;
            satp_on = (mode == 0);
            for (int s = 0; s < 2; s++) begin
                lookup(s, next_rand());
                lookup(s, 32'h1234_5678);
            end
        end
    endtask

    task automatic test_translate();
        mmu_pkg::vaddr_t va;
        priv = mmu_pkg::PRIV_S;
        satp_on = 1'b1;
        for (int s = 0; s < 2; s++) begin
            va = next_rand();
            lookup(s, va);
            refill(s, 3, va, mmu_pkg::ppn_t'(next_rand()), make_flags(1, 1, 0), 1'b0);
            lookup(s, va);
            lookup(s, {va[31:12], 12'(next_rand())});
            va = next_rand();
            refill(s, 5, va, mmu_pkg::ppn_t'(next_rand()), make_flags(1, 1, 0), 1'b1);
            for (int k = 0; k < 4; k++) begin
                lookup(s, {va[31:22], 22'(next_rand())});
            end
        end
    endtask

    task automatic test_perm();
        refill(0, 0, 32'h4000_2000, 20'h5_0002, make_flags(1, 0, 0), 1'b0);
        lookup(0, 32'h4000_2abc);
        refill(1, 0, 32'h4000_3000, 20'h5_0003, make_flags(0, 1, 0), 1'b0);
        lookup(1, 32'h4000_3010);
        mxr = 1'b1;
        lookup(1, 32'h4000_3010);
        mxr = 1'b0;
        for (int s = 0; s < 2; s++) begin
            refill(s, 1, 32'h4000_4000, 20'h5_0004, make_flags(1, 1, 1), 1'b0);
            refill(s, 2, 32'h4000_5000, 20'h5_0005, make_flags(1, 1, 0), 1'b0);
            lookup(s, 32'h4000_4004);
            sum = 1'b1;
            lookup(s, 32'h4000_4004);
            sum = 1'b0;
            priv = mmu_pkg::PRIV_U;
            lookup(s, 32'h4000_5008);
            lookup(s, 32'h4000_4008);
            priv = mmu_pkg::PRIV_S;
        end
    endtask

    task automatic test_pmp();
        // Region of 16 pages at 0x8000_0000
        pmp_base[0] = 20'h8_0000;
        pmp_mask[0] = 20'hf_fff0;
        for (int s = 0; s < 2; s++) begin
            refill(s, 4, 32'h4001_0000, 20'h8_0002, make_flags(1, 1, 0), 1'b0);
            refill(s, 6, 32'h4001_1000, 20'h4_0020, make_flags(1, 1, 0), 1'b0);
        end
        for (int p = 0; p < 2; p++) begin
            pmp_perm[0] = (p == 0) ? 3'b100 : 3'b001;
            for (int s = 0; s < 2; s++) begin
                lookup(s, 32'h4001_0040);
                lookup(s, 32'h4001_1040);
            end
        end
        pmp_perm[0] = '0;
    endtask

    task automatic test_fence();
        refill(1, 7, 32'h4002_0000, 20'h6_0000, make_flags(1, 1, 0), 1'b0);
        refill(1, 8, 32'h4002_1000, 20'h6_0001, make_flags(1, 1, 0), 1'b0);
        lookup(1, 32'h4002_0100);
        lookup(1, 32'h4002_1100);
        run_fence(1, 1'b0, 32'h4002_0123, 3);
        lookup(1, 32'h4002_0100);
        lookup(1, 32'h4002_1100);
        lookup(0, 32'h4000_5000);
    endtask

    task automatic test_fence_all();
        for (int s = 0; s < 2; s++) begin
            run_fence(s, 1'b1, '0, `TLB_DEPTH + 2);
            for (int i = 0; i < `TLB_DEPTH; i++) begin
                lookup(s, {m_vpn[s][i], 12'h0});
            end
        end
    endtask

    initial begin
        init_inputs();
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        step();
        test_bypass();
        finish_test("bypass");
        test_translate();
        finish_test("translate");
        test_perm();
        finish_test("permission");
        test_pmp();
        finish_test("pmp");
        test_fence();
        finish_test("fence");
        test_fence_all();
        finish_test("fence_all");
        $display("Tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("Timeout: the simulation did not finish within %0d cycles",
                 NUM_TESTS * 200);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hdl
hdl/mmu_pkg.sv
hdl/pri_encoder.sv
hdl/pmp_check.sv
hdl/l1_tlb.sv
hdl/mmu_l1.sv
tb/tb_mmu_l1.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mmu_l1
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
